// ==== hw/game_pkg.sv ====
package game_pkg;

    // match flow states
    // SHOOTER is reserved for the multiplayer link and never entered here
    typedef enum logic [2:0] {
        START   = 3'd0,
        KEEPER  = 3'd1,
        SHOOTER = 3'd2,
        WINNER  = 3'd3,
        LOOSER  = 3'd4
    } g_state;

    // game mode, latched in START only
    typedef enum logic {
        SOLO  = 1'b0,
        MULTI = 1'b1
    } g_mode;

    // round counter width, holds 0..LAST_ROUND
    localparam int ROUND_W = 4;

    // saves counter width
    localparam int SCORE_W = 3;

    // shots in one match
    localparam int LAST_ROUND = 4;

    // saves needed for a win
    localparam int WIN_SCORE = 3;

endpackage

// ==== hw/game_state_sel.sv ====
`timescale 1ns/1ps

module game_state_sel import game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               left_clicked,
    input  logic               solo_enable,
    input  logic               is_scored,
    input  logic [ROUND_W-1:0] round_counter,
    input  logic [SCORE_W-1:0] score,
    output g_state             game_state,
    output g_mode              game_mode
);

    g_state game_state_nxt;
    g_mode  game_mode_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= START;
            game_mode  <= MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    // solo only picked up in START, kept during a match
    always_comb begin
        if (!solo_enable) begin
            game_mode_nxt = MULTI;
        end else if (game_state == START) begin
            game_mode_nxt = SOLO;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    always_comb begin
        game_state_nxt = game_state;
        case (game_mode)
            SOLO: begin
                case (game_state)
                    START: begin
                        if (left_clicked) begin
                            game_state_nxt = KEEPER;
                        end
                    end
                    KEEPER: begin
                        // decided on the result of the last shot
                        if (is_scored && round_counter == ROUND_W'(LAST_ROUND)) begin
                            if (score >= SCORE_W'(WIN_SCORE)) begin
                                game_state_nxt = WINNER;
                            end else begin
                                game_state_nxt = LOOSER;
                            end
                        end
                    end
                    WINNER, LOOSER: begin
                        // click acknowledges the result
                        if (left_clicked) begin
                            game_state_nxt = START;
                        end
                    end
                    SHOOTER: begin
                        // not reachable in solo play
                        game_state_nxt = START;
                    end
                    default: begin
                        game_state_nxt = START;
                    end
                endcase
            end
            MULTI: begin
                // no link yet, stay idle
                game_state_nxt = START;
            end
            default: begin
                game_state_nxt = START;
            end
        endcase
    end

endmodule

// ==== hw/input_pkg.sv ====
package input_pkg;

    // shot and dive sides share one encoding
    typedef enum logic [1:0] {
        DIR_LEFT   = 2'd0,
        DIR_CENTER = 2'd1,
        DIR_RIGHT  = 2'd2
    } dir_t;

    // pointer x position width
    localparam int XPOS_W = 12;

    // screen split in three zones
    localparam int ZONE_LEFT_MAX  = 341;
    localparam int ZONE_RIGHT_MIN = 683;

    // shot timing and queue size
    localparam int KICK_PERIOD = 8;
    localparam int FIFO_DEPTH  = 2;

    // shot lfsr, taps 7 5 4 3
    localparam int LFSR_W = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'h5A;

endpackage

// ==== hw/kick_fifo.sv ====
`timescale 1ns/1ps

module kick_fifo import game_pkg::*, input_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    input  logic   push,
    input  dir_t   push_dir,
    input  logic   pop,
    output dir_t   head_dir,
    output logic   full,
    output logic   empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // pending shot storage
    dir_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // no writes while the match is idle
    assign wr_en = push && !full && (game_state != START);
    assign rd_en = pop && !empty;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign head_dir = mem[rd_ptr];

    // shot side storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_dir;
        end
    end

    // pointers wrap at depth
    always_ff @(posedge clk) begin
        if (rst || game_state == START) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/kick_gen.sv ====
`timescale 1ns/1ps

module kick_gen import game_pkg::*, input_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    input  logic   full,
    output logic   push,
    output dir_t   push_dir
);

    localparam int TMR_W = $clog2(KICK_PERIOD);

    // shot beat timer
    logic [TMR_W-1:0]   tmr;
    logic               tick;
    // shots scheduled this match
    logic [ROUND_W-1:0] shot_cnt;
    // a shot waiting for room in the queue
    logic               pending;
    logic [LFSR_W-1:0]  lfsr;
    logic [LFSR_W-1:0]  lfsr_next;

    // end of one beat, only while the keeper plays
    assign tick = (game_state == KEEPER) && (tmr == TMR_W'(KICK_PERIOD - 1));

    // fibonacci step, feedback into bit 0
    assign lfsr_next = {lfsr[LFSR_W-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    // stalls while the queue is full, dir and lfsr held
    assign push = pending && !full && (game_state == KEEPER);

    // low two bits pick the side, 3 folds onto center
    always_comb begin
        case (lfsr_next[1:0])
            2'd0:    push_dir = DIR_LEFT;
            2'd2:    push_dir = DIR_RIGHT;
            default: push_dir = DIR_CENTER;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tmr      <= '0;
            shot_cnt <= '0;
            pending  <= 1'b0;
            lfsr     <= LFSR_SEED;
        end else begin
            // timer restarts on every entry into KEEPER
            if (game_state != KEEPER || tick) begin
                tmr <= '0;
            end else begin
                tmr <= tmr + 1'b1;
            end
            // sequence only moves on an issued shot
            if (push) begin
                lfsr <= lfsr_next;
            end
            if (game_state == START) begin
                shot_cnt <= '0;
                pending  <= 1'b0;
            end else if (tick && shot_cnt < ROUND_W'(LAST_ROUND) && (!pending || push)) begin
                // new shot, replaces the one leaving now if any
                pending  <= 1'b1;
                shot_cnt <= shot_cnt + 1'b1;
            end else if (push) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/penalty_top.sv ====
`timescale 1ns/1ps

module penalty_top import game_pkg::*, input_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               mouse_left,
    input  logic [XPOS_W-1:0]  mouse_xpos,
    input  logic               solo_enable,
    output g_state             game_state,
    output g_mode              game_mode,
    output logic               is_scored,
    output logic [ROUND_W-1:0] round_counter,
    output logic [SCORE_W-1:0] score,
    output dir_t               kick_dir
);

    // click and dive path
    logic left_clicked;
    dir_t dive_dir;
    logic dive_valid;
    // shot path
    logic push;
    dir_t push_dir;
    logic full;
    logic empty;
    dir_t head_dir;
    logic shot_taken;

    player_input u_player_input (
        .clk          (clk),
        .rst          (rst),
        .mouse_left   (mouse_left),
        .mouse_xpos   (mouse_xpos),
        .game_state   (game_state),
        .shot_taken   (shot_taken),
        .left_clicked (left_clicked),
        .dive_dir     (dive_dir),
        .dive_valid   (dive_valid)
    );

    // producer
    kick_gen u_kick_gen (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .full       (full),
        .push       (push),
        .push_dir   (push_dir)
    );

    // shots not yet answered, popped by the score keeper
    kick_fifo u_kick_fifo (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .push       (push),
        .push_dir   (push_dir),
        .pop        (shot_taken),
        .head_dir   (head_dir),
        .full       (full),
        .empty      (empty)
    );

    // consumer
    score_keeper u_score_keeper (
        .clk           (clk),
        .rst           (rst),
        .game_state    (game_state),
        .dive_valid    (dive_valid),
        .dive_dir      (dive_dir),
        .head_dir      (head_dir),
        .empty         (empty),
        .shot_taken    (shot_taken),
        .is_scored     (is_scored),
        .round_counter (round_counter),
        .score         (score),
        .kick_dir      (kick_dir)
    );

    game_state_sel u_game_state_sel (
        .clk           (clk),
        .rst           (rst),
        .left_clicked  (left_clicked),
        .solo_enable   (solo_enable),
        .is_scored     (is_scored),
        .round_counter (round_counter),
        .score         (score),
        .game_state    (game_state),
        .game_mode     (game_mode)
    );

endmodule

// ==== hw/player_input.sv ====
`timescale 1ns/1ps

module player_input import game_pkg::*, input_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              mouse_left,
    input  logic [XPOS_W-1:0] mouse_xpos,
    input  g_state            game_state,
    input  logic              shot_taken,
    output logic              left_clicked,
    output dir_t              dive_dir,
    output logic              dive_valid
);

    // previous button level
    logic mouse_left_q;
    // side under the pointer right now
    dir_t zone_dir;

    // three zones, boundaries belong to the outer sides
    always_comb begin
        if (mouse_xpos <= XPOS_W'(ZONE_LEFT_MAX)) begin
            zone_dir = DIR_LEFT;
        end else if (mouse_xpos >= XPOS_W'(ZONE_RIGHT_MIN)) begin
            zone_dir = DIR_RIGHT;
        end else begin
            zone_dir = DIR_CENTER;
        end
    end

    // rising edge of the button gives one click pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_left_q <= 1'b0;
            left_clicked <= 1'b0;
        end else begin
            mouse_left_q <= mouse_left;
            left_clicked <= mouse_left & ~mouse_left_q;
        end
    end

    // dive latch, one dive per shot
    always_ff @(posedge clk) begin
        if (rst) begin
            dive_valid <= 1'b0;
        end else if (game_state == START || shot_taken) begin
            // consumed by the score keeper, or new match
            dive_valid <= 1'b0;
        end else if (left_clicked && game_state == KEEPER && !dive_valid) begin
            dive_valid <= 1'b1;
        end
    end

    // side captured together with the valid flag
    always_ff @(posedge clk) begin
        if (left_clicked && game_state == KEEPER && !dive_valid) begin
            dive_dir <= zone_dir;
        end
    end

endmodule

// ==== hw/score_keeper.sv ====
`timescale 1ns/1ps

module score_keeper import game_pkg::*, input_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  g_state             game_state,
    input  logic               dive_valid,
    input  dir_t               dive_dir,
    input  dir_t               head_dir,
    input  logic               empty,
    output logic               shot_taken,
    output logic               is_scored,
    output logic [ROUND_W-1:0] round_counter,
    output logic [SCORE_W-1:0] score,
    output dir_t               kick_dir
);

    // same side means the keeper saved it
    logic saved;

    assign saved = (dive_dir == head_dir);

    // a dive meets the oldest shot, pops it and clears the dive
    assign shot_taken = dive_valid && !empty && (game_state == KEEPER);

    // round result strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            is_scored <= 1'b0;
        end else begin
            is_scored <= shot_taken;
        end
    end

    // counters, zeroed for each new match
    always_ff @(posedge clk) begin
        if (rst || game_state == START) begin
            round_counter <= '0;
            score         <= '0;
        end else if (shot_taken) begin
            round_counter <= round_counter + 1'b1;
            if (saved) begin
                score <= score + 1'b1;
            end
        end
    end

    // resolved shot side, shown with is_scored
    always_ff @(posedge clk) begin
        if (shot_taken) begin
            kick_dir <= head_dir;
        end
    end

endmodule

// ==== src.f ====
hw/game_pkg.sv
hw/input_pkg.sv
hw/player_input.sv
hw/kick_gen.sv
hw/kick_fifo.sv
hw/score_keeper.sv
hw/game_state_sel.sv
hw/penalty_top.sv
testbench/penalty_tb.sv

// ==== testbench/penalty_tb.sv ====
`timescale 1ns/1ps

module penalty_tb import game_pkg::*, input_pkg::*; ();

    // hang guard for six matches of four rounds each
    localparam int TIMEOUT_CYCLES = 6 * (LAST_ROUND * (KICK_PERIOD + 40) + 50);
    localparam int N_MATCHES = 6;

    logic               clk;
    logic               rst;
    logic               mouse_left;
    logic [XPOS_W-1:0]  mouse_xpos;
    logic               solo_enable;
    g_state             game_state;
    g_mode              game_mode;
    logic               is_scored;
    logic [ROUND_W-1:0] round_counter;
    logic [SCORE_W-1:0] score;
    dir_t               kick_dir;

    // dive zones in click order for the checker
    dir_t        dive_q[$];
    // separate lfsr copies for aiming and for checking
    logic [7:0]  aim_lfsr;
    logic [7:0]  chk_lfsr;
    logic [31:0] rng;
    int          cycles;
    int          exp_round;
    int          exp_saves;
    int          final_saves;
    logic        outcome_due;
    int          boundary_x[4] = '{341, 342, 682, 683};

    penalty_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .mouse_left    (mouse_left),
        .mouse_xpos    (mouse_xpos),
        .solo_enable   (solo_enable),
        .game_state    (game_state),
        .game_mode     (game_mode),
        .is_scored     (is_scored),
        .round_counter (round_counter),
        .score         (score),
        .kick_dir      (kick_dir)
    );

    always #20 clk = ~clk;

    // fibonacci step with taps 7 5 4 3 into bit 0
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // low two bits give the side and 3 counts as center
    function automatic dir_t shot_dir(input logic [7:0] s);
        case (s[1:0])
            2'd0:    return DIR_LEFT;
            2'd2:    return DIR_RIGHT;
            default: return DIR_CENTER;
        endcase
    endfunction

    // screen zone under pointer x
    function automatic dir_t zone_of(input int x);
        if (x <= ZONE_LEFT_MAX) begin
            return DIR_LEFT;
        end else if (x >= ZONE_RIGHT_MIN) begin
            return DIR_RIGHT;
        end
        return DIR_CENTER;
    endfunction

    // any side but the shot
    function automatic dir_t miss_of(input dir_t d);
        case (d)
            DIR_LEFT:   return DIR_CENTER;
            DIR_CENTER: return DIR_RIGHT;
            default:    return DIR_LEFT;
        endcase
    endfunction

    // expected state once the last round is in
    function automatic g_state outcome_of(input int saves);
        return (saves >= WIN_SCORE) ? WINNER : LOOSER;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
            fail_run();
        end
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // button held for two cycles at pointer x
    task automatic click_at(input int x);
        next_cycle();
        mouse_xpos = XPOS_W'(x);
        mouse_left = 1'b1;
        next_cycle();
        next_cycle();
        mouse_left = 1'b0;
    endtask

    task automatic wait_scored();
        @(negedge clk);
        while (!is_scored) begin
            @(negedge clk);
        end
    endtask

    // random x inside the given zone
    task automatic pick_x(input dir_t d, output int x);
        rng = lcg_step(rng);
        case (d)
            DIR_LEFT:   x = int'(rng[31:24]);
            DIR_CENTER: x = 342 + int'(rng[31:24]);
            default:    x = 683 + int'(rng[31:24]);
        endcase
    endtask

    // style picks the dive pattern and 2 also waits for a full queue
    task automatic play_match(input int style);
        dir_t want;
        int   x;
        int   r;
        click_at(512);
        while (game_state != KEEPER) begin
            next_cycle();
        end
        if (style == 2) begin
            repeat (4 * KICK_PERIOD) next_cycle();
        end
        for (r = 0; r < LAST_ROUND; r++) begin
            aim_lfsr = lfsr_step(aim_lfsr);
            want = shot_dir(aim_lfsr);
            case (style)
                0: x = boundary_x[r];
                1: pick_x(want, x);
                3: pick_x((r < 3) ? want : miss_of(want), x);
                4: pick_x((r < 2) ? want : miss_of(want), x);
                default: begin
                    rng = lcg_step(rng);
                    x = int'(rng[31:22]);
                end
            endcase
            dive_q.push_back(zone_of(x));
            click_at(x);
            wait_scored();
        end
        // match leaves KEEPER after the last round
        while (game_state == KEEPER) begin
            next_cycle();
        end
        click_at(512);
        while (game_state != START) begin
            next_cycle();
        end
        next_cycle();
        check("round_counter after return", 0, int'(round_counter));
        check("score after return", 0, int'(score));
    endtask

    // compares every result strobe with the reference model
    always @(negedge clk) begin : compare
        dir_t exp_dir;
        dir_t dive;
        if (!rst) begin
            if (outcome_due) begin
                check("match outcome", int'(outcome_of(final_saves)), int'(game_state));
                outcome_due = 1'b0;
            end
            if (is_scored) begin
                chk_lfsr = lfsr_step(chk_lfsr);
                exp_dir = shot_dir(chk_lfsr);
                if (dive_q.size() == 0) begin
                    $display("is_scored pulsed with no dive pending in the testbench");
                    fail_run();
                end
                dive = dive_q.pop_front();
                exp_round++;
                if (dive == exp_dir) begin
                    exp_saves++;
                end
                check("kick_dir", int'(exp_dir), int'(kick_dir));
                check("round_counter", exp_round, int'(round_counter));
                check("score", exp_saves, int'(score));
                if (exp_round == LAST_ROUND) begin
                    // state is judged one cycle later
                    outcome_due = 1'b1;
                    final_saves = exp_saves;
                    exp_round = 0;
                    exp_saves = 0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles without finishing", cycles);
            fail_run();
        end
    end

    initial begin
        int m;
        clk = 1'b0;
        rst = 1'b1;
        mouse_left = 1'b0;
        mouse_xpos = '0;
        solo_enable = 1'b0;
        aim_lfsr = LFSR_SEED;
        chk_lfsr = LFSR_SEED;
        rng = 32'h3818bea9;
        cycles = 0;
        exp_round = 0;
        exp_saves = 0;
        final_saves = 0;
        outcome_due = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // multi mode ignores clicks
        click_at(500);
        next_cycle();
        next_cycle();
        check("state in multi", int'(START), int'(game_state));
        check("mode in multi", int'(MULTI), int'(game_mode));
        solo_enable = 1'b1;
        next_cycle();
        check("mode latch in start", int'(SOLO), int'(game_mode));
        click_at(500);
        check("state after start click", int'(KEEPER), int'(game_state));
        // drop solo mid match and raise it again while still in KEEPER
        solo_enable = 1'b0;
        next_cycle();
        check("mode after solo drop", int'(MULTI), int'(game_mode));
        check("state one edge after drop", int'(KEEPER), int'(game_state));
        solo_enable = 1'b1;
        next_cycle();
        check("mode after raise in keeper", int'(MULTI), int'(game_mode));
        check("state after mode drop", int'(START), int'(game_state));
        next_cycle();
        check("mode relatch in start", int'(SOLO), int'(game_mode));

        for (m = 0; m < N_MATCHES; m++) begin
            play_match(m);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
